//--- hdl/lr_defs.svh
`ifndef LR_DEFS_SVH
`define LR_DEFS_SVH

// Data path widths.
`define LR_DATA_W   8       // One byte.
`define LR_ADDR_W   16      // Bus address and PC.

// Flag bit positions within F, low nibble of F is always zero.
`define LR_FLAG_Z   7       // Zero.
`define LR_FLAG_N   6       // Subtract.
`define LR_FLAG_H   5       // Half carry.
`define LR_FLAG_C   4       // Carry.

// Bus timing.
`define LR_PHASES   4       // Clocks per machine cycle.

// Start address after reset.
`define LR_RESET_PC 16'h0000

`endif

//--- hdl/lr_pkg.sv
`default_nettype none

package lr_pkg;

	// Sequencer state, one machine cycle each.
	typedef enum logic [2:0] {
		st_ifetch,          // Base bank opcode fetch.
		st_cb_ifetch,       // Second opcode after the CB prefix.
		st_imml_fetch,      // Immediate byte or low address byte.
		st_immh_fetch,      // High address byte of JP.
		st_indirect_fetch,  // Read from (HL).
		st_indirect_store,  // Write to (HL).
		st_jump             // Internal cycle, PC reload.
	} seq_state_t;

	// Write-back class for the register file.
	typedef enum logic [2:0] {
		ex_none,            // No register or flag update.
		ex_load,            // LD r,src.
		ex_alu,             // Accumulator op with flags.
		ex_incdec,          // INC/DEC r, C kept.
		ex_cb_shift,        // CB rotate, shift, SWAP.
		ex_cb_bit,          // CB BIT, flags only.
		ex_cb_setres        // CB SET/RES, no flags.
	} exec_class_t;

endpackage

`default_nettype wire

//--- hdl/lr_alu.sv
`timescale 1ns/1ns
`include "lr_defs.svh"
`default_nettype none

module lr_alu (
	input  wire  [`LR_DATA_W-1:0]        op,           // Opcode, bits 5..3 pick the op.
	input  wire  [`LR_DATA_W-1:0]        a,            // Accumulator.
	input  wire  [`LR_DATA_W-1:0]        arg,          // Register, (HL) or immediate.
	input  wire  [`LR_FLAG_Z:`LR_FLAG_C] flags,
	output logic [`LR_DATA_W-1:0]        result,
	output logic [`LR_FLAG_Z:`LR_FLAG_C] result_flags
);
	logic [`LR_DATA_W:0] wide;      // Result plus carry or borrow.
	logic [4:0]          nib;       // Low nibble plus half carry.
	logic                cin;       // Carry in for ADC and SBC.
	logic                fn;
	logic                fh;
	logic                fc;

	always_comb
	begin
		cin          = op[3] & ~op[5] & flags[`LR_FLAG_C]; // Only ADC (001) and SBC (011).
		wide         = {1'b0, a};
		nib          = {1'b0, a[3:0]};
		fn           = 1'b0;
		fh           = 1'b0;
		fc           = 1'b0;
		result       = a;
		result_flags = flags;
		if (op[7:6] == 2'b00)
		begin
			// INC/DEC on the operand, carry untouched.
			result = op[0] ? arg - 1'b1 : arg + 1'b1;
			result_flags[`LR_FLAG_Z] = ~|result;
			result_flags[`LR_FLAG_N] = op[0];                            // Set on DEC.
			result_flags[`LR_FLAG_H] = op[0] ? arg[3:0] == 4'h0 : arg[3:0] == 4'hf;
		end
		else
		begin
			case (op[5:3])
			3'd0, 3'd1:                                                 // ADD, ADC.
			begin
				wide = {1'b0, a} + {1'b0, arg} + {{`LR_DATA_W{1'b0}}, cin};
				nib  = {1'b0, a[3:0]} + {1'b0, arg[3:0]} + {4'd0, cin};
			end
			3'd2, 3'd3, 3'd7:                                           // SUB, SBC, CP.
			begin
				wide = {1'b0, a} - {1'b0, arg} - {{`LR_DATA_W{1'b0}}, cin};
				nib  = {1'b0, a[3:0]} - {1'b0, arg[3:0]} - {4'd0, cin};
				fn   = 1'b1;
			end
			3'd4:                                                       // AND.
			begin
				wide = {1'b0, a & arg};
				nib  = 5'h10;                                           // H always set.
			end
			3'd5: wide = {1'b0, a ^ arg};                               // XOR.
			default: wide = {1'b0, a | arg};                            // OR.
			endcase
			fh           = nib[4];
			fc           = wide[`LR_DATA_W];
			result       = wide[`LR_DATA_W-1:0];
			result_flags = {~|result, fn, fh, fc};                      // Z N H C.
		end
	end

endmodule

`default_nettype wire

//--- hdl/lr_shift_unit.sv
`timescale 1ns/1ns
`include "lr_defs.svh"
`default_nettype none

module lr_shift_unit (
	input  wire  [`LR_DATA_W-1:0]        op,           // CB bank opcode.
	input  wire  [`LR_DATA_W-1:0]        arg,          // Register from bits 2..0.
	input  wire  [`LR_FLAG_Z:`LR_FLAG_C] flags,
	output logic [`LR_DATA_W-1:0]        result,
	output logic [`LR_FLAG_Z:`LR_FLAG_C] result_flags
);
	logic [`LR_DATA_W-1:0] rot;    // Rotate/shift result.
	logic                  rot_c;  // Bit shifted out.

	// Rotate and shift kinds, bits 5..3.
	always_comb
	begin
		case (op[5:3])
		3'd0: {rot_c, rot} = {arg, arg[`LR_DATA_W-1]};                    // RLC.
		3'd1: {rot, rot_c} = {arg[0], arg};                               // RRC.
		3'd2: {rot_c, rot} = {arg, flags[`LR_FLAG_C]};                    // RL through carry.
		3'd3: {rot, rot_c} = {flags[`LR_FLAG_C], arg};                    // RR through carry.
		3'd4: {rot_c, rot} = {arg, 1'b0};                                 // SLA.
		3'd5: {rot, rot_c} = {arg[`LR_DATA_W-1], arg};                    // SRA keeps sign.
		3'd6: {rot_c, rot} = {1'b0, arg[3:0], arg[7:4]};                  // SWAP nibbles.
		default: {rot, rot_c} = {1'b0, arg};                              // SRL.
		endcase
	end

	// Group select, bits 7..6.
	always_comb
	begin
		result       = arg;
		result_flags = flags;
		case (op[7:6])
		2'b00:
		begin
			result       = rot;
			result_flags = {~|rot, 1'b0, 1'b0, rot_c};                    // Z N H C.
		end
		2'b01:                                                            // BIT n.
			result_flags = {~arg[op[5:3]], 1'b0, 1'b1, flags[`LR_FLAG_C]};
		default:
			result[op[5:3]] = op[6];                                      // RES (10), SET (11).
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/lr_reg_file.sv
`timescale 1ns/1ns
`include "lr_defs.svh"
`default_nettype none

module lr_reg_file (
	input  wire                          clk,
	input  wire                          reset,
	input  wire  [`LR_DATA_W-1:0]        op,
	input  wire  [`LR_DATA_W-1:0]        imml,         // Immediate or (HL) byte.
	input  wire  lr_pkg::exec_class_t    exec_class,
	input  wire                          exec,         // Write-back strobe.
	input  wire  [`LR_DATA_W-1:0]        alu_result,
	input  wire  [`LR_FLAG_Z:`LR_FLAG_C] alu_flags,
	input  wire  [`LR_DATA_W-1:0]        shift_result,
	input  wire  [`LR_FLAG_Z:`LR_FLAG_C] shift_flags,
	output logic [`LR_DATA_W-1:0]        arg,
	output logic [`LR_DATA_W-1:0]        a,
	output logic [`LR_FLAG_Z:`LR_FLAG_C] flags,
	output logic [`LR_DATA_W-1:0]        store_data,   // Source byte for (HL) stores.
	output logic [`LR_ADDR_W-1:0]        hl
);
	import lr_pkg::*;

	localparam logic [2:0] IDX_H  = 3'd4;
	localparam logic [2:0] IDX_L  = 3'd5;
	localparam logic [2:0] IDX_HL = 3'd6;                // Memory slot, not a register.
	localparam logic [2:0] IDX_A  = 3'd7;

	logic [`LR_DATA_W-1:0]        regs [0:7];            // B C D E H L - A.
	logic [`LR_FLAG_Z:`LR_FLAG_C] f_q;
	logic [2:0]                   src_idx;
	logic [2:0]                   wr_idx;
	logic [`LR_DATA_W-1:0]        wr_data;
	logic                         wr_en;
	logic                         f_en;
	logic [`LR_FLAG_Z:`LR_FLAG_C] f_next;

	assign src_idx    = (exec_class == ex_incdec) ? op[5:3] : op[2:0]; // INC/DEC reads its dest.
	assign arg        = (src_idx == IDX_HL) ? imml : regs[src_idx];
	assign store_data = (op[2:0] == IDX_HL) ? imml : regs[op[2:0]];
	assign a          = regs[IDX_A];
	assign hl         = {regs[IDX_H], regs[IDX_L]};
	assign flags      = f_q;

	// Destination and flag source per class.
	always_comb
	begin
		wr_en   = 1'b0;
		wr_idx  = op[5:3];
		wr_data = arg;
		f_en    = 1'b0;
		f_next  = alu_flags;
		case (exec_class)
		ex_load: wr_en = 1'b1;
		ex_alu:
		begin
			wr_en   = op[5:3] != 3'd7;                      // CP only sets flags.
			wr_idx  = IDX_A;
			wr_data = alu_result;
			f_en    = 1'b1;
		end
		ex_incdec:
		begin
			wr_en   = 1'b1;
			wr_data = alu_result;
			f_en    = 1'b1;
		end
		ex_cb_shift, ex_cb_setres:
		begin
			wr_en   = 1'b1;
			wr_idx  = op[2:0];
			wr_data = shift_result;
			f_en    = exec_class == ex_cb_shift;
			f_next  = shift_flags;
		end
		ex_cb_bit:
		begin
			f_en   = 1'b1;
			f_next = shift_flags;
		end
		default: ;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (exec && wr_en && wr_idx != IDX_HL)
			regs[wr_idx] <= wr_data;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			f_q <= '0;
		else if (exec && f_en)
			f_q <= f_next;
	end

endmodule

`default_nettype wire

//--- hdl/lr_sequencer.sv
`timescale 1ns/1ns
`include "lr_defs.svh"
`default_nettype none

module lr_sequencer (
	input  wire                          clk,
	input  wire                          reset,
	input  wire  [`LR_DATA_W-1:0]        din,          // Valid while read is high.
	input  wire  [`LR_FLAG_Z:`LR_FLAG_C] flags,
	input  wire  [`LR_DATA_W-1:0]        store_data,
	input  wire  [`LR_ADDR_W-1:0]        hl,           // Address of (HL) forms.
	output logic [`LR_ADDR_W-1:0]        adr,
	output logic [`LR_DATA_W-1:0]        dout,
	output logic                         ddrv,
	output logic                         read,
	output logic                         write,
	output logic [`LR_ADDR_W-1:0]        pc,
	output logic [`LR_DATA_W-1:0]        op,
	output logic                         op_bank,      // Set for CB bank opcodes.
	output logic [`LR_DATA_W-1:0]        imml,
	output lr_pkg::exec_class_t          exec_class,
	output logic                         exec
);
	import lr_pkg::*;

	localparam int PHASE_W = $clog2(`LR_PHASES);

	seq_state_t            state;
	seq_state_t            next_state;
	logic [PHASE_W-1:0]    phase;
	logic                  last_phase;
	logic                  fetch_state;                  // Reads at PC.
	logic [`LR_DATA_W-1:0] immh;
	logic [`LR_ADDR_W-1:0] pc_sum;
	logic                  is_ld_rr;
	logic                  is_ld_imm;
	logic                  is_alu_r;
	logic                  is_alu_imm;
	logic                  is_incdec;
	logic                  is_jp;
	logic                  is_jr;
	logic                  hl_src;
	logic                  hl_dst;
	logic                  need_imm;
	logic                  cond_flag;
	logic                  take;

	// Base bank decode.
	assign is_ld_rr   = op[7:6] == 2'b01 && op != 8'h76;                    // HALT slot excluded.
	assign is_ld_imm  = op[7:6] == 2'b00 && op[2:0] == 3'd6;                // LD r,d8 and (HL),d8.
	assign is_alu_r   = op[7:6] == 2'b10;
	assign is_alu_imm = op[7:6] == 2'b11 && op[2:0] == 3'd6;
	assign is_incdec  = op[7:6] == 2'b00 && op[2:1] == 2'b10 && op[5:3] != 3'd6;
	assign is_jp      = op == 8'hc3 || (op[7:5] == 3'b110 && op[2:0] == 3'd2);
	assign is_jr      = op == 8'h18 || (op[7:5] == 3'b001 && op[2:0] == 3'd0);
	assign hl_src     = (is_ld_rr || is_alu_r) && op[2:0] == 3'd6;
	assign hl_dst     = is_ld_rr && op[5:3] == 3'd6;
	assign need_imm   = is_ld_imm || is_alu_imm || is_jp || is_jr;

	// Bit 4 picks C or Z, bit 3 the polarity.
	assign cond_flag  = op[4] ? flags[`LR_FLAG_C] : flags[`LR_FLAG_Z];
	assign take       = op == 8'hc3 || op == 8'h18 || cond_flag == op[3];

	// Shared adder, PC increment or JR target.
	assign pc_sum = pc + ((state == st_jump) ?
		{{(`LR_ADDR_W-`LR_DATA_W){imml[`LR_DATA_W-1]}}, imml} :
		{{(`LR_ADDR_W-1){1'b0}}, 1'b1});

	assign last_phase  = phase == PHASE_W'(`LR_PHASES - 1);
	assign fetch_state = state == st_ifetch || state == st_cb_ifetch ||
		state == st_imml_fetch || state == st_immh_fetch;
	assign exec        = last_phase && next_state == st_ifetch; // Final cycle of the instruction.

	always_comb
	begin
		next_state = st_ifetch;
		case (state)
		st_ifetch:
			if (op == 8'hcb)
				next_state = st_cb_ifetch;
			else if (need_imm)
				next_state = st_imml_fetch;
			else if (hl_src)
				next_state = st_indirect_fetch;
			else if (hl_dst)
				next_state = st_indirect_store;
		st_imml_fetch:
			if (op == 8'h36)
				next_state = st_indirect_store;                             // LD (HL),d8.
			else if (is_jp)
				next_state = st_immh_fetch;
			else if (is_jr && take)
				next_state = st_jump;
		st_immh_fetch:
			if (take)
				next_state = st_jump;
		default: ;
		endcase
	end

	always_comb
	begin
		exec_class = ex_none;
		if (op_bank)
		begin
			if (op[2:0] != 3'd6)
				case (op[7:6])
				2'b00: exec_class = ex_cb_shift;
				2'b01: exec_class = ex_cb_bit;
				default: exec_class = ex_cb_setres;
				endcase
		end
		else if ((is_ld_rr || is_ld_imm) && op[5:3] != 3'd6)
			exec_class = ex_load;
		else if (is_alu_r || is_alu_imm)
			exec_class = ex_alu;
		else if (is_incdec)
			exec_class = ex_incdec;
	end

	// Phase counter, state, strobes and PC.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= st_ifetch;
			phase <= '0;
			read  <= 1'b0;
			write <= 1'b0;
			ddrv  <= 1'b0;
			pc    <= `LR_RESET_PC;
		end
		else
		begin
			phase <= last_phase ? '0 : phase + 1'b1;
			if (last_phase)
				state <= next_state;
			case (phase)
			0: ddrv <= state == st_indirect_store;                          // Drops in the next cycle.
			1:
			begin
				read  <= fetch_state || state == st_indirect_fetch;
				write <= state == st_indirect_store;
				if (fetch_state)
					pc <= pc_sum;
			end
			2: write <= 1'b0;
			default:
			begin
				read <= 1'b0;
				if (state == st_jump)
					pc <= is_jp ? {immh, imml} : pc_sum;
			end
			endcase
		end
	end

	// Address, data and opcode latches.
	always_ff @(posedge clk)
	begin
		if (phase == 0 && fetch_state)
			adr <= pc;
		if (phase == 2)
			case (state)
			st_ifetch, st_cb_ifetch:
			begin
				op      <= din;
				op_bank <= state == st_cb_ifetch;
			end
			st_imml_fetch, st_indirect_fetch: imml <= din;
			st_immh_fetch: immh <= din;
			default: ;
			endcase
		if (last_phase && (next_state == st_indirect_fetch || next_state == st_indirect_store))
		begin
			adr  <= hl;                                                     // Set ahead of the access.
			dout <= store_data;
		end
	end

endmodule

`default_nettype wire

//--- hdl/lr_core.sv
`timescale 1ns/1ns
`include "lr_defs.svh"
`default_nettype none

module lr_core (
	input  wire                          clk,
	input  wire                          reset,
	output logic [`LR_ADDR_W-1:0]        adr,
	input  wire  [`LR_DATA_W-1:0]        din,
	output logic [`LR_DATA_W-1:0]        dout,
	output logic                         ddrv,         // Core drives the data bus.
	output logic                         read,
	output logic                         write,
	output logic [`LR_ADDR_W-1:0]        pc,
	output logic [`LR_FLAG_Z:`LR_FLAG_C] f
);
	import lr_pkg::*;

	logic [`LR_DATA_W-1:0]        op;
	logic [`LR_DATA_W-1:0]        imml;
	logic [`LR_DATA_W-1:0]        arg;
	logic [`LR_DATA_W-1:0]        a;
	logic [`LR_DATA_W-1:0]        store_data;
	logic [`LR_DATA_W-1:0]        alu_result;
	logic [`LR_DATA_W-1:0]        shift_result;
	logic [`LR_FLAG_Z:`LR_FLAG_C] alu_flags;
	logic [`LR_FLAG_Z:`LR_FLAG_C] shift_flags;
	logic [`LR_ADDR_W-1:0]        hl;
	exec_class_t                  exec_class;
	logic                         exec;

	lr_sequencer lr_sequencer_i (.clk(clk), .reset(reset), .din(din), .flags(f),
		.store_data(store_data), .hl(hl), .adr(adr), .dout(dout), .ddrv(ddrv),
		.read(read), .write(write), .pc(pc), .op(op), .op_bank(), .imml(imml),
		.exec_class(exec_class), .exec(exec));

	lr_alu lr_alu_i (.op(op), .a(a), .arg(arg), .flags(f),
		.result(alu_result), .result_flags(alu_flags));

	lr_shift_unit lr_shift_unit_i (.op(op), .arg(arg), .flags(f),
		.result(shift_result), .result_flags(shift_flags));

	lr_reg_file lr_reg_file_i (.clk(clk), .reset(reset), .op(op), .imml(imml),
		.exec_class(exec_class), .exec(exec), .alu_result(alu_result),
		.alu_flags(alu_flags), .shift_result(shift_result), .shift_flags(shift_flags),
		.arg(arg), .a(a), .flags(f), .store_data(store_data), .hl(hl));

endmodule

`default_nettype wire

//--- test/tb_lr_ref.svh
`ifndef TB_LR_REF_SVH
`define TB_LR_REF_SVH

// Accumulator op, returns {A after the op, flags}.
function automatic logic [11:0] alu_expect(input logic [2:0] kind, input logic [7:0] a,
	input logic [7:0] b, input logic [7:4] fin);
	int         ia;
	int         ib;
	int         cy;
	int         full;
	int         half;
	logic [7:0] res;
	logic [7:4] fo;
	ia   = a;
	ib   = b;
	cy   = (kind == 3'd1 || kind == 3'd3) ? int'(fin[`LR_FLAG_C]) : 0; // ADC, SBC only.
	fo   = '0;
	full = 0;
	half = 0;
	case (kind)
	3'd0, 3'd1:
	begin
		full = ia + ib + cy;
		half = (ia % 16) + (ib % 16) + cy;
		fo[`LR_FLAG_C] = full > 255;
		fo[`LR_FLAG_H] = half > 15;
	end
	3'd2, 3'd3, 3'd7:
	begin
		full = ia - ib - cy;
		half = (ia % 16) - (ib % 16) - cy;
		fo[`LR_FLAG_N] = 1'b1;
		fo[`LR_FLAG_C] = full < 0;                      // Borrow.
		fo[`LR_FLAG_H] = half < 0;
	end
	3'd4:
	begin
		full = ia & ib;
		fo[`LR_FLAG_H] = 1'b1;
	end
	3'd5: full = ia ^ ib;
	default: full = ia | ib;
	endcase
	fo[`LR_FLAG_Z] = (full & 255) == 0;
	res = (kind == 3'd7) ? a : full[7:0];                   // CP keeps A.
	return {res, fo};
endfunction

// INC or DEC of one register, carry passes through.
function automatic logic [11:0] incdec_expect(input logic dec, input logic [7:0] v,
	input logic [7:4] fin);
	logic [7:0] res;
	logic [7:4] fo;
	res = dec ? v - 8'd1 : v + 8'd1;
	fo  = fin;
	fo[`LR_FLAG_Z] = res == 8'd0;
	fo[`LR_FLAG_N] = dec;
	fo[`LR_FLAG_H] = dec ? (v % 16) == 0 : (v % 16) == 15;
	return {res, fo};
endfunction

// CB bank op on one register.
function automatic logic [11:0] cb_expect(input logic [7:0] op, input logic [7:0] v,
	input logic [7:4] fin);
	logic [7:0] res;
	logic [7:4] fo;
	logic       out_bit;
	int         n;
	n       = op[5:3];
	res     = v;
	fo      = fin;
	out_bit = 1'b0;
	case (op[7:6])
	2'b00:
	begin
		case (n)
		0: res = (v << 1) | (v >> 7);
		1: res = (v >> 1) | (v << 7);
		2: res = (v << 1) | {7'd0, fin[`LR_FLAG_C]};
		3: res = (v >> 1) | {fin[`LR_FLAG_C], 7'd0};
		4: res = v << 1;
		5: res = (v >> 1) | (v & 8'h80);                 // Sign copied.
		6: res = (v << 4) | (v >> 4);
		default: res = v >> 1;
		endcase
		if (n == 6)
			out_bit = 1'b0;
		else if (n % 2 == 0)
			out_bit = v[7];                              // Left kinds.
		else
			out_bit = v[0];
		fo = {res == 8'd0, 1'b0, 1'b0, out_bit};
	end
	2'b01: fo = {((v >> n) & 8'd1) == 8'd0, 1'b0, 1'b1, fin[`LR_FLAG_C]};
	2'b10: res = v & ~(8'd1 << n);
	default: res = v | (8'd1 << n);
	endcase
	return {res, fo};
endfunction

// Branch decision for JP and JR opcodes.
function automatic logic cond_taken(input logic [7:0] op, input logic [7:4] fin);
	if (op == 8'hc3 || op == 8'h18)
		return 1'b1;
	case (op[4:3])
	2'd0: return !fin[`LR_FLAG_Z];                       // NZ.
	2'd1: return fin[`LR_FLAG_Z];
	2'd2: return !fin[`LR_FLAG_C];                       // NC.
	default: return fin[`LR_FLAG_C];
	endcase
endfunction

`endif

//--- test/tb_lr_core.sv
`timescale 1ns/1ns
`include "lr_defs.svh"
`default_nettype none

module tb_lr_core;
	localparam int ALU_N = 16;                               // Eight ops, both forms.
	localparam int CB_N  = 32;                               // Each group, each bit index.
	localparam int JMP_N = 10;                               // One per jump opcode.
	// Worst case machine cycles per test, reset counted as one.
	localparam int WORST_MC = 4 + 35 + (5 + 8 * ALU_N) + 39 + (5 + 6 * CB_N) + (5 + 14 * JMP_N);
	localparam longint WATCHDOG_NS = longint'(WORST_MC) * 3 / 2 * `LR_PHASES * 40;

	logic                         clk = 1'b0;
	logic                         reset = 1'b1;
	logic [`LR_DATA_W-1:0]        din;
	logic [`LR_ADDR_W-1:0]        adr;
	logic [`LR_DATA_W-1:0]        dout;
	logic                         ddrv;
	logic                         read;
	logic                         write;
	logic [`LR_ADDR_W-1:0]        pc;
	logic [`LR_FLAG_Z:`LR_FLAG_C] f;

	logic [7:0]  mem [0:65535];
	logic [15:0] wp;                                         // Program write pointer.
	logic [15:0] ex_adr [$];
	logic [7:0]  ex_dat [$];
	logic [7:4]  ex_f [$];
	int          st_count;
	int          test_err;
	int          n_pass = 0;
	int          n_fail = 0;
	integer      seed = 32'h4c96ff7b;
	string       cur_name;

	`include "tb_lr_ref.svh"

	lr_core lr_core_i (.clk(clk), .reset(reset), .adr(adr), .din(din), .dout(dout),
		.ddrv(ddrv), .read(read), .write(write), .pc(pc), .f(f));

	always #20 clk = ~clk;

	assign din = read ? mem[adr] : 8'h00;                    // Zero wait state memory.

	// Store capture and compare.
	always @(posedge write)
	begin
		if (!ddrv)
		begin
			$display("%s: write strobe rose while ddrv was low", cur_name);
			test_err++;
		end
		mem[adr] = dout;
		if (st_count >= ex_dat.size())
		begin
			$display("%s: unexpected store of %h at %h", cur_name, dout, adr);
			test_err++;
		end
		else
		begin
			if (adr != ex_adr[st_count])
			begin
				$display("mismatch %s store %0d adr: expected %h actual %h",
					cur_name, st_count, ex_adr[st_count], adr);
				test_err++;
			end
			if (dout != ex_dat[st_count])
			begin
				$display("mismatch %s store %0d data: expected %h actual %h",
					cur_name, st_count, ex_dat[st_count], dout);
				test_err++;
			end
			if (f != ex_f[st_count])
			begin
				$display("mismatch %s store %0d flags: expected %h actual %h",
					cur_name, st_count, ex_f[st_count], f);
				test_err++;
			end
		end
		st_count++;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired in %s, the DUT stopped making progress", cur_name);
		$display("TEST FAIL");
		$finish;
	end

	// Hold reset, wipe memory and expectations.
	task automatic begin_test(input string name);
		@(negedge clk);
		reset = 1'b1;
		for (int i = 0; i < 65536; i++)
			mem[i] = 8'h00;
		ex_adr.delete();
		ex_dat.delete();
		ex_f.delete();
		st_count = 0;
		test_err = 0;
		wp       = 16'h0000;
		cur_name = name;
	endtask

	task automatic put(input logic [7:0] b);
		mem[wp] = b;
		wp      = wp + 16'd1;
	endtask

	task automatic ld_imm(input logic [2:0] r, input logic [7:0] v);
		put({2'b00, r, 3'd6});
		put(v);
	endtask

	task automatic store_reg(input logic [2:0] r);
		put({5'b01110, r});                                  // LD (HL),r.
	endtask

	task automatic expect_store(input logic [15:0] a, input logic [7:0] d, input logic [7:4] fl);
		ex_adr.push_back(a);
		ex_dat.push_back(d);
		ex_f.push_back(fl);
	endtask

	// Close the program with JR -2, release reset, wait for all stores.
	task automatic run_program();
		put(8'h18);
		put(8'hfe);
		repeat (3) @(negedge clk);
		reset = 1'b0;
		while (st_count < ex_dat.size())
			@(posedge clk);
		@(negedge clk);
	endtask

	task automatic end_test();
		if (test_err == 0)
		begin
			$display("[%s] ok, %0d stores", cur_name, st_count);
			n_pass++;
		end
		else
		begin
			$display("[%s] bad, %0d errors", cur_name, test_err);
			n_fail++;
		end
	endtask

	initial
	begin
		logic [7:0]  vals [0:7];
		logic [15:0] hl;
		logic [11:0] r;
		logic [7:4]  ef;
		logic [7:0]  a0;
		logic [7:0]  b0;
		logic [7:0]  cbop;
		logic [7:0]  jop;
		logic [7:0]  tk;
		logic [7:0]  nt;
		logic [2:0]  kind;
		logic [15:0] t;
		logic [7:0]  jops [0:9];

		jops = '{8'hc3, 8'hc2, 8'hca, 8'hd2, 8'hda, 8'h18, 8'h20, 8'h28, 8'h30, 8'h38};

		begin_test("reset_state");
		put(8'h18);
		put(8'hfe);
		repeat (3) @(negedge clk);
		if (read !== 1'b0 || write !== 1'b0 || ddrv !== 1'b0)
		begin
			$display("%s: bus strobes not low during reset", cur_name);
			test_err++;
		end
		if (pc !== `LR_RESET_PC)
		begin
			$display("mismatch %s pc in reset: expected %h actual %h",
				cur_name, `LR_RESET_PC, pc);
			test_err++;
		end
		reset = 1'b0;
		@(posedge read);
		if (adr !== `LR_RESET_PC)
		begin
			$display("mismatch %s first read adr: expected %h actual %h",
				cur_name, `LR_RESET_PC, adr);
			test_err++;
		end
		@(negedge clk);
		if (pc !== `LR_RESET_PC + 16'd1)                     // Stepped with the read strobe.
		begin
			$display("mismatch %s pc after first read: expected %h actual %h",
				cur_name, `LR_RESET_PC + 16'd1, pc);
			test_err++;
		end
		end_test();

		begin_test("ld_store");
		for (int i = 0; i < 8; i++)
			vals[i] = $random(seed);
		vals[4] = vals[4] | 8'h80;                           // Keep HL above the program.
		hl = {vals[4], vals[5]};
		for (int i = 0; i < 8; i++)
			if (i != 6)
				ld_imm(i[2:0], vals[i]);
		for (int i = 0; i < 8; i++)
			if (i != 6)
			begin
				store_reg(i[2:0]);
				expect_store(hl, vals[i], 4'h0);
			end
		put(8'h47);                                          // LD B,A.
		store_reg(3'd0);
		expect_store(hl, vals[7], 4'h0);
		put(8'h36);                                          // LD (HL),d8.
		put(8'h5a);
		expect_store(hl, 8'h5a, 4'h0);
		run_program();
		end_test();

		begin_test("alu_ops");
		hl = 16'h9000;
		ld_imm(3'd4, hl[15:8]);
		ld_imm(3'd5, hl[7:0]);
		ef = 4'h0;                                           // Cleared by reset.
		for (int i = 0; i < ALU_N; i++)
		begin
			a0   = $random(seed);
			b0   = $random(seed);
			kind = i[2:0];                                   // Every op, CP included.
			ld_imm(3'd7, a0);
			ld_imm(3'd0, b0);
			if (!i[3])
			begin
				put({2'b11, kind, 3'd6});
				put(b0);
			end
			else
				put({2'b10, kind, 3'd0});                    // Operand in B.
			store_reg(3'd7);
			r  = alu_expect(kind, a0, b0, ef);
			ef = r[3:0];
			expect_store(hl, r[11:4], ef);
		end
		run_program();
		end_test();

		begin_test("inc_dec");
		hl = 16'h9010;
		ld_imm(3'd4, hl[15:8]);
		ld_imm(3'd5, hl[7:0]);
		ld_imm(3'd7, 8'hff);
		put(8'hc6);                                          // ADD A,1 sets carry.
		put(8'h01);
		r  = alu_expect(3'd0, 8'hff, 8'h01, 4'h0);
		ef = r[3:0];
		for (int i = 0; i < 6; i++)
		begin
			a0 = (i / 2 == 0) ? 8'h00 : (i / 2 == 1) ? 8'h0f : 8'hff;
			ld_imm(3'd1, a0);
			put((i % 2 == 1) ? 8'h0d : 8'h0c);
			store_reg(3'd1);
			r  = incdec_expect(i % 2 == 1, a0, ef);
			ef = r[3:0];
			expect_store(hl, r[11:4], ef);
		end
		run_program();
		end_test();

		begin_test("cb_ops");
		hl = 16'h9020;
		ld_imm(3'd4, hl[15:8]);
		ld_imm(3'd5, hl[7:0]);
		ef = 4'h0;
		for (int i = 0; i < CB_N; i++)
		begin
			a0   = $random(seed);
			cbop = {i[1:0], i[4:2], 3'd2};                   // Each group and kind, register D.
			ld_imm(3'd2, a0);
			put(8'hcb);
			put(cbop);
			store_reg(3'd2);
			r  = cb_expect(cbop, a0, ef);
			ef = r[3:0];
			expect_store(hl, r[11:4], ef);
		end
		run_program();
		end_test();

		begin_test("jumps");
		hl = 16'h9030;
		ld_imm(3'd4, hl[15:8]);
		ld_imm(3'd5, hl[7:0]);
		ef = 4'h0;
		for (int i = 0; i < JMP_N; i++)
		begin
			a0 = $random(seed);
			b0 = $random(seed);
			case (i % 4)                                     // Walk all Z/C combinations.
			0:
			begin
				a0 = a0 | 8'h01;
				b0 = 8'h00 - a0;
			end
			1:
			begin
				a0 = (a0 & 8'h7f) | 8'h01;
				b0 = b0 & 8'h7f;
			end
			2:
			begin
				a0 = a0 | 8'h81;
				b0 = b0 | 8'h80;
			end
			default:
			begin
				a0 = 8'h00;
				b0 = 8'h00;
			end
			endcase
			ld_imm(3'd7, a0);
			put(8'hc6);
			put(b0);
			r   = alu_expect(3'd0, a0, b0, ef);
			ef  = r[3:0];
			jop = jops[i];
			tk  = 8'h80 | i[7:0];
			nt  = 8'h10 | i[7:0];
			put(jop);
			if (jop[7])
			begin
				t = wp + 16'd6;                              // Taken block after the skip.
				put(t[7:0]);
				put(t[15:8]);
			end
			else
				put(8'h04);
			put(8'h36);
			put(nt);
			put(8'h18);
			put(8'h02);
			put(8'h36);
			put(tk);
			expect_store(hl, cond_taken(jop, ef) ? tk : nt, ef);
		end
		run_program();
		end_test();

		$display("tests run %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
		if (n_fail == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
+incdir+hdl
+incdir+test
hdl/lr_pkg.sv
hdl/lr_alu.sv
hdl/lr_shift_unit.sv
hdl/lr_reg_file.sv
hdl/lr_sequencer.sv
hdl/lr_core.sv
test/tb_lr_core.sv

//--- run.sh
#!/bin/sh
# Build with Verilator and run, status follows the testbench result.
verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_lr_core -o tb_lr_core \
	&& ./obj_dir/tb_lr_core | tee /dev/stderr | grep -q "TEST PASS" \
	&& echo "simulation passed" && exit 0 \
	|| { echo "simulation failed"; exit 1; }
